// ==== dv/program_stimulus.txt ====
# I addr instr | D addr data | W test pc reg value | S test addr data
# all fields hex, W and S lines in program order
I 00000000 24010005
I 00000004 2402FFFD
I 00000008 3C031234
I 0000000C 00222021
I 00000010 00222823
I 00000014 00223024
I 00000018 00223825
I 0000001C 0041402A
I 00000020 0022482A
I 00000024 240A0001
I 00000028 014A5021
I 0000002C 014A5821
I 00000030 016A6021
I 00000034 018A6823
I 00000038 8C0E0100
I 0000003C 01C17821
I 00000040 24100200
I 00000044 AE0F0000
I 00000048 8E110000
I 0000004C 10220002
I 00000050 24120007
I 00000054 14220002
I 00000058 24130009
I 0000005C 24140BAD
I 00000060 12730002
I 00000064 24150015
I 00000068 24140BAD
I 0000006C 16520002
I 00000070 24160016
I 00000074 08000020
I 00000078 24170017
I 0000007C 24140BAD
I 00000080 24000001
I 00000084 24180018
I 00000088 08000022
D 00000100 0000ABCD
W 1 00000000 01 00000005
W 1 00000004 02 FFFFFFFD
W 1 00000008 03 12340000
W 1 0000000C 04 00000002
W 1 00000010 05 00000008
W 1 00000014 06 00000005
W 1 00000018 07 FFFFFFFD
W 1 0000001C 08 00000001
W 1 00000020 09 00000000
W 2 00000024 0A 00000001
W 2 00000028 0A 00000002
W 2 0000002C 0B 00000004
W 2 00000030 0C 00000006
W 2 00000034 0D 00000004
W 3 00000038 0E 0000ABCD
W 3 0000003C 0F 0000ABD2
W 4 00000040 10 00000200
S 4 00000200 0000ABD2
W 4 00000048 11 0000ABD2
W 5 00000050 12 00000007
W 5 00000058 13 00000009
W 5 00000064 15 00000015
W 5 00000070 16 00000016
W 5 00000078 17 00000017
W 6 00000084 18 00000018

// ==== verilog.f ====
verilog/mips_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory_writeback.sv
verilog/regfile.sv
verilog/hazard.sv
verilog/datapath.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_top.sv ====
module tb_top;
    import mips_pkg::*;

    localparam word_t start_pc = 32'h0000_0000;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    word_t     instr;
    logic      mread_en;
    logic      mwrite_en;
    word_t     mread_addr;
    word_t     mwrite_addr;
    word_t     mwrite_data;
    word_t     rd;
    logic      rfwrite_en;
    reg_addr_t rfwrite_addr;
    word_t     rfwrite_data;
    word_t     wb_pc;
    logic      stallF;
    logic      flush_ex;
    int        tests_passed;
    int        tests_failed;
    int        stray_errors;
    logic      all_done;

    word_t imem [1024];
    word_t dmem [1024];
    word_t dinit [1024];
    int    load_ok;
    int    cycles;
    int    drain;

    always #10 clk = ~clk;

    datapath #(.reset_pc(start_pc)) dut0 (
        .clk, .rst_n, .pc, .instr, .mread_en, .mwrite_en, .mread_addr,
        .mwrite_addr, .mwrite_data, .rd, .rfwrite_en, .rfwrite_addr,
        .rfwrite_data, .wb_pc, .stallF, .flush_ex
    );

    tb_checker #(.reset_pc(start_pc)) checker0 (
        .clk, .rst_n, .pc, .mread_en, .stallF, .flush_ex, .rfwrite_en,
        .rfwrite_addr, .rfwrite_data, .wb_pc, .mwrite_en, .mwrite_addr,
        .mwrite_data, .tests_passed, .tests_failed, .stray_errors, .all_done
    );

    // both memories answer in the same cycle
    assign instr = imem[pc[11:2]];
    // reads return zero while the read strobe is low
    assign rd    = mread_en ? dmem[mread_addr[11:2]] : '0;

    // data memory reloads its image while reset is held
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) begin
                dmem[i] <= dinit[i];
            end
        end else if (mwrite_en) begin
            dmem[mwrite_addr[11:2]] <= mwrite_data;
        end
    end

    task automatic load_stimulus(output int ok);
        int    fd;
        int    n;
        string line;
        string tag;
        word_t f1;
        word_t f2;
        word_t f3;
        word_t f4;
        ok = 0;
        fd = $fopen("dv/program_stimulus.txt", "r");
        if (fd != 0) begin
            ok = 1;
            while (!$feof(fd)) begin
                line = "";
                tag  = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h", tag, f1, f2, f3, f4);
                    if (tag == "I") begin
                        imem[f1[11:2]] = f2;
                    end else if (tag == "D") begin
                        dinit[f1[11:2]] = f2;
                    end else if (tag == "W") begin
                        checker0.add_write(f1, f2, f3[4:0], f4);
                    end else if (tag == "S") begin
                        checker0.add_store(f1, f2, f3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        void'($urandom(57397));
        // unused words read as nop
        // data fill follows the address
        for (int i = 0; i < 1024; i++) begin
            imem[i]  = '0;
            dinit[i] = 32'hA5A5_0000 ^ (word_t'(i) << 2);
        end
        load_stimulus(load_ok);
        if (load_ok == 0) begin
            $display("could not open dv/program_stimulus.txt");
            $display("Finished with errors");
        end else begin
            drain = 16 + int'($urandom % 8);
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            cycles = 0;
            while (!all_done && cycles < 2000) begin
                @(posedge clk);
                cycles++;
            end
            if (!all_done) begin
                $display("timeout after %0d cycles waiting for the expected trace", cycles);
                checker0.report_missing();
            end else begin
                // extra window to catch stray writes after the last entry
                for (int k = 0; k < drain; k++) begin
                    @(posedge clk);
                end
            end
            $display("tests passed: %0d, tests failed: %0d, other errors: %0d",
                     tests_passed, tests_failed, stray_errors);
            if (all_done && tests_failed == 0 && stray_errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
        end
        $finish;
    end

endmodule

// ==== dv/tb_checker.sv ====
module tb_checker #(
    parameter logic [31:0] reset_pc = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pc,
    input  logic        mread_en,
    input  logic        stallF,
    input  logic        flush_ex,
    input  logic        rfwrite_en,
    input  logic [4:0]  rfwrite_addr,
    input  logic [31:0] rfwrite_data,
    input  logic [31:0] wb_pc,
    input  logic        mwrite_en,
    input  logic [31:0] mwrite_addr,
    input  logic [31:0] mwrite_data,
    output int          tests_passed,
    output int          tests_failed,
    output int          stray_errors,
    output logic        all_done
);
    int          w_count = 0;
    int          s_count = 0;
    int          w_idx;
    int          s_idx;
    int          exp_w_test [64];
    logic [31:0] exp_w_pc [64];
    logic [4:0]  exp_w_reg [64];
    logic [31:0] exp_w_val [64];
    int          exp_s_test [64];
    logic [31:0] exp_s_addr [64];
    logic [31:0] exp_s_data [64];
    int          test_total [16] = '{default: 0};
    int          test_seen [16];
    int          test_bad [16];
    logic        reset_checked;

    task automatic add_write(input int t, input logic [31:0] p, input logic [4:0] r,
                             input logic [31:0] v);
        exp_w_test[w_count] = t;
        exp_w_pc[w_count]   = p;
        exp_w_reg[w_count]  = r;
        exp_w_val[w_count]  = v;
        test_total[t]++;
        w_count++;
    endtask

    task automatic add_store(input int t, input logic [31:0] a, input logic [31:0] d);
        exp_s_test[s_count] = t;
        exp_s_addr[s_count] = a;
        exp_s_data[s_count] = d;
        test_total[t]++;
        s_count++;
    endtask

    task automatic entry_done(input int t);
        test_seen[t]++;
        if (test_seen[t] == test_total[t]) begin
            if (test_bad[t] == 0) begin
                $display("test %0d passed", t);
                tests_passed++;
            end else begin
                $display("test %0d failed with %0d wrong values", t, test_bad[t]);
                tests_failed++;
            end
        end
    endtask

    // first cycle out of reset
    task automatic check_reset_state();
        if (pc !== reset_pc) begin
            $display("MISMATCH at %0t: pc %h after reset, expected %h", $time, pc, reset_pc);
            stray_errors++;
        end
        if (mread_en !== 1'b0 || mwrite_en !== 1'b0 || rfwrite_en !== 1'b0 ||
            stallF !== 1'b0 || flush_ex !== 1'b0) begin
            $display("%0t: a strobe or hazard flag was high right after reset", $time);
            stray_errors++;
        end
    endtask

    task automatic check_write();
        int t;
        if (rfwrite_addr == 5'd0) begin
            $display("%0t: register 0 showed up on the write trace", $time);
            stray_errors++;
        end else if (w_idx >= w_count) begin
            $display("%0t: unexpected write r%0d = %h from pc %h", $time,
                     rfwrite_addr, rfwrite_data, wb_pc);
            stray_errors++;
        end else begin
            t = exp_w_test[w_idx];
            if (wb_pc !== exp_w_pc[w_idx] || rfwrite_addr !== exp_w_reg[w_idx] ||
                rfwrite_data !== exp_w_val[w_idx]) begin
                $display("MISMATCH at %0t: write pc %h r%0d = %h, expected pc %h r%0d = %h",
                         $time, wb_pc, rfwrite_addr, rfwrite_data, exp_w_pc[w_idx],
                         exp_w_reg[w_idx], exp_w_val[w_idx]);
                test_bad[t]++;
            end
            w_idx++;
            entry_done(t);
        end
    endtask

    task automatic check_store();
        int t;
        if (s_idx >= s_count) begin
            $display("%0t: unexpected store of %h to %h", $time, mwrite_data, mwrite_addr);
            stray_errors++;
        end else begin
            t = exp_s_test[s_idx];
            if (mwrite_addr !== exp_s_addr[s_idx] || mwrite_data !== exp_s_data[s_idx]) begin
                $display("MISMATCH at %0t: store %h to %h, expected %h to %h", $time,
                         mwrite_data, mwrite_addr, exp_s_data[s_idx], exp_s_addr[s_idx]);
                test_bad[t]++;
            end
            s_idx++;
            entry_done(t);
        end
    endtask

    task automatic report_missing();
        if (w_idx < w_count) begin
            $display("register write %0d of test %0d (pc %h) never came", w_idx,
                     exp_w_test[w_idx], exp_w_pc[w_idx]);
        end
        if (s_idx < s_count) begin
            $display("store %0d of test %0d (address %h) never came", s_idx,
                     exp_s_test[s_idx], exp_s_addr[s_idx]);
        end
    endtask

    assign all_done = (w_count > 0) && (w_idx == w_count) && (s_idx == s_count);

    // DUT outputs are registered and settled by the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            w_idx         = 0;
            s_idx         = 0;
            tests_passed  = 0;
            tests_failed  = 0;
            stray_errors  = 0;
            reset_checked = 1'b0;
            for (int i = 0; i < 16; i++) begin
                test_seen[i] = 0;
                test_bad[i]  = 0;
            end
        end else begin
            if (!reset_checked) begin
                check_reset_state();
                reset_checked = 1'b1;
            end
            if (rfwrite_en) begin
                check_write();
            end
            if (mwrite_en) begin
                check_store();
            end
        end
    end

endmodule

// ==== verilog/datapath.sv ====
module datapath #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    output mips_pkg::word_t     pc,
    input  mips_pkg::word_t     instr,
    output logic                mread_en,
    output logic                mwrite_en,
    output mips_pkg::word_t     mread_addr,
    output mips_pkg::word_t     mwrite_addr,
    output mips_pkg::word_t     mwrite_data,
    input  mips_pkg::word_t     rd,
    output logic                rfwrite_en,
    output mips_pkg::reg_addr_t rfwrite_addr,
    output mips_pkg::word_t     rfwrite_data,
    output mips_pkg::word_t     wb_pc,
    output logic                stallF,
    output logic                flush_ex
);
    import mips_pkg::*;

    logic      branch_taken, uses_rs, uses_rt, is_branch;
    word_t     branch_target, rs_data, rt_data;
    reg_addr_t rs, rt, d_dest, e_dest, m_dest;
    word_t     d_pc, d_a, d_b, d_imm;
    alu_op_t   d_alu_op;
    logic      d_use_imm, d_reg_wen, d_is_load, d_is_store;
    fwd_sel_t  fwd_a, fwd_b, br_fwd_a, br_fwd_b;
    logic      e_reg_wen, e_is_load, e_is_store, m_reg_wen, m_is_load;
    word_t     e_result, e_store_data, e_pc, mem_result;

    fetch #(.reset_pc(reset_pc)) fetch0 (
        .clk, .rst_n, .stall(stallF), .branch_taken, .branch_target, .pc
    );

    decode decode0 (
        .clk, .rst_n, .stall(stallF), .instr, .f_pc(pc), .rs_data, .rt_data,
        .mem_result, .wb_result(rfwrite_data), .br_fwd_a, .br_fwd_b,
        .rs, .rt, .uses_rs, .uses_rt, .is_branch, .branch_taken, .branch_target,
        .d_pc, .d_a, .d_b, .d_imm, .d_alu_op, .d_use_imm, .d_reg_wen,
        .d_is_load, .d_is_store, .d_dest
    );

    execute execute0 (
        .clk, .rst_n, .bubble(flush_ex), .d_pc, .d_a, .d_b, .d_imm, .d_alu_op,
        .d_use_imm, .d_reg_wen, .d_is_load, .d_is_store, .d_dest, .fwd_a, .fwd_b,
        .mem_result, .wb_result(rfwrite_data), .e_dest, .e_reg_wen, .e_is_load,
        .e_is_store, .e_result, .e_store_data, .e_pc
    );

    memory_writeback memory_writeback0 (
        .clk, .rst_n, .e_dest, .e_reg_wen, .e_is_load, .e_is_store, .e_result,
        .e_store_data, .e_pc, .rd, .mread_en, .mwrite_en, .mread_addr,
        .mwrite_addr, .mwrite_data, .m_dest, .m_reg_wen, .m_is_load, .mem_result,
        .w_dest(rfwrite_addr), .w_reg_wen(rfwrite_en), .wb_result(rfwrite_data),
        .wb_pc
    );

    regfile regfile0 (
        .clk, .rst_n, .wen(rfwrite_en), .waddr(rfwrite_addr), .raddr_a(rs),
        .raddr_b(rt), .wdata(rfwrite_data), .rdata_a(rs_data), .rdata_b(rt_data)
    );

    hazard hazard0 (
        .rs, .rt, .uses_rs, .uses_rt, .is_branch, .e_dest, .m_dest,
        .w_dest(rfwrite_addr), .e_reg_wen, .e_is_load, .m_reg_wen, .m_is_load,
        .w_reg_wen(rfwrite_en), .fwd_a, .fwd_b, .br_fwd_a, .br_fwd_b,
        .stall(stallF), .bubble(flush_ex)
    );

endmodule

// ==== verilog/hazard.sv ====
module hazard (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                uses_rs,
    input  logic                uses_rt,
    input  logic                is_branch,
    input  mips_pkg::reg_addr_t e_dest,
    input  mips_pkg::reg_addr_t m_dest,
    input  mips_pkg::reg_addr_t w_dest,
    input  logic                e_reg_wen,
    input  logic                e_is_load,
    input  logic                m_reg_wen,
    input  logic                m_is_load,
    input  logic                w_reg_wen,
    output mips_pkg::fwd_sel_t  fwd_a,
    output mips_pkg::fwd_sel_t  fwd_b,
    output mips_pkg::fwd_sel_t  br_fwd_a,
    output mips_pkg::fwd_sel_t  br_fwd_b,
    output logic                stall,
    output logic                bubble
);
    import mips_pkg::*;

    logic rs_e, rt_e, rs_m, rt_m, rs_w, rt_w;
    logic load_use;
    logic branch_hold;

    // producer matches, $0 is never forwarded
    assign rs_e = uses_rs && e_reg_wen && e_dest != '0 && e_dest == rs;
    assign rt_e = uses_rt && e_reg_wen && e_dest != '0 && e_dest == rt;
    assign rs_m = uses_rs && m_reg_wen && m_dest != '0 && m_dest == rs;
    assign rt_m = uses_rt && m_reg_wen && m_dest != '0 && m_dest == rt;
    assign rs_w = uses_rs && w_reg_wen && w_dest == rs;
    assign rt_w = uses_rt && w_reg_wen && w_dest == rt;

    // registered by execute, so one stage further on by then
    assign fwd_a = rs_e ? fwd_mem : (rs_m ? fwd_wb : fwd_rf);
    assign fwd_b = rt_e ? fwd_mem : (rt_m ? fwd_wb : fwd_rf);

    // comparator reads in decode right away
    assign br_fwd_a = rs_m ? fwd_mem : (rs_w ? fwd_wb : fwd_rf);
    assign br_fwd_b = rt_m ? fwd_mem : (rt_w ? fwd_wb : fwd_rf);

    assign load_use    = e_is_load && (rs_e || rt_e);
    assign branch_hold = is_branch && (rs_e || rt_e || (m_is_load && (rs_m || rt_m)));

    assign stall  = load_use || branch_hold;
    assign bubble = load_use || branch_hold;

endmodule

// ==== verilog/regfile.sv ====
module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wen,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::reg_addr_t raddr_a,
    input  mips_pkg::reg_addr_t raddr_b,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rdata_a,
    output mips_pkg::word_t     rdata_b
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through to the reads
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (wen && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (wen && waddr == raddr_b) ? wdata : regs[raddr_b];

    // writeback is expected to filter $0
    a_no_zero_write: assert property (
        @(posedge clk) disable iff (!rst_n) wen |-> waddr != '0
    ) else $error("write to register 0");

endmodule

// ==== verilog/memory_writeback.sv ====
module memory_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t e_dest,
    input  logic                e_reg_wen,
    input  logic                e_is_load,
    input  logic                e_is_store,
    input  mips_pkg::word_t     e_result,
    input  mips_pkg::word_t     e_store_data,
    input  mips_pkg::word_t     e_pc,
    input  mips_pkg::word_t     rd,
    output logic                mread_en,
    output logic                mwrite_en,
    output mips_pkg::word_t     mread_addr,
    output mips_pkg::word_t     mwrite_addr,
    output mips_pkg::word_t     mwrite_data,
    output mips_pkg::reg_addr_t m_dest,
    output logic                m_reg_wen,
    output logic                m_is_load,
    output mips_pkg::word_t     mem_result,
    output mips_pkg::reg_addr_t w_dest,
    output logic                w_reg_wen,
    output mips_pkg::word_t     wb_result,
    output mips_pkg::word_t     wb_pc
);
    import mips_pkg::*;

    word_t m_pc;

    // execute/memory register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_reg_wen <= 1'b0;
            m_is_load <= 1'b0;
            mwrite_en <= 1'b0;
        end else begin
            m_reg_wen <= e_reg_wen;
            m_is_load <= e_is_load;
            mwrite_en <= e_is_store;
        end
    end

    always_ff @(posedge clk) begin
        m_dest      <= e_dest;
        mem_result  <= e_result;
        mwrite_data <= e_store_data;
        m_pc        <= e_pc;
    end

    // data port is driven straight from the register
    assign mread_en    = m_is_load;
    assign mread_addr  = mem_result;
    assign mwrite_addr = mem_result;

    // memory/writeback register, $0 never gets written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_reg_wen <= 1'b0;
        end else begin
            w_reg_wen <= m_reg_wen && (m_dest != '0);
        end
    end

    always_ff @(posedge clk) begin
        w_dest    <= m_dest;
        wb_result <= m_is_load ? rd : mem_result;
        wb_pc     <= m_pc;
    end

    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mread_en && mwrite_en)
    ) else $error("data read and write strobes both high");

endmodule

// ==== verilog/execute.sv ====
module execute (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                bubble,
    input  mips_pkg::word_t     d_pc,
    input  mips_pkg::word_t     d_a,
    input  mips_pkg::word_t     d_b,
    input  mips_pkg::word_t     d_imm,
    input  mips_pkg::alu_op_t   d_alu_op,
    input  logic                d_use_imm,
    input  logic                d_reg_wen,
    input  logic                d_is_load,
    input  logic                d_is_store,
    input  mips_pkg::reg_addr_t d_dest,
    input  mips_pkg::fwd_sel_t  fwd_a,
    input  mips_pkg::fwd_sel_t  fwd_b,
    input  mips_pkg::word_t     mem_result,
    input  mips_pkg::word_t     wb_result,
    output mips_pkg::reg_addr_t e_dest,
    output logic                e_reg_wen,
    output logic                e_is_load,
    output logic                e_is_store,
    output mips_pkg::word_t     e_result,
    output mips_pkg::word_t     e_store_data,
    output mips_pkg::word_t     e_pc
);
    import mips_pkg::*;

    word_t    q_a;
    word_t    q_b;
    word_t    q_imm;
    alu_op_t  q_alu_op;
    logic     q_use_imm;
    fwd_sel_t q_fwd_a;
    fwd_sel_t q_fwd_b;
    word_t    op_a;
    word_t    alu_b;

    // control part of the decode/execute register
    always_ff @(posedge clk) begin
        if (!rst_n || bubble) begin
            e_reg_wen  <= 1'b0;
            e_is_load  <= 1'b0;
            e_is_store <= 1'b0;
            q_fwd_a    <= fwd_rf;
            q_fwd_b    <= fwd_rf;
        end else begin
            e_reg_wen  <= d_reg_wen;
            e_is_load  <= d_is_load;
            e_is_store <= d_is_store;
            q_fwd_a    <= fwd_a;
            q_fwd_b    <= fwd_b;
        end
    end

    always_ff @(posedge clk) begin
        q_a       <= d_a;
        q_b       <= d_b;
        q_imm     <= d_imm;
        q_alu_op  <= d_alu_op;
        q_use_imm <= d_use_imm;
        e_dest    <= d_dest;
        e_pc      <= d_pc;
    end

    // selects were picked a cycle ago when the producers sat one stage back
    always_comb begin
        case (q_fwd_a)
            fwd_mem: op_a = mem_result;
            fwd_wb:  op_a = wb_result;
            default: op_a = q_a;
        endcase
        case (q_fwd_b)
            fwd_mem: e_store_data = mem_result;
            fwd_wb:  e_store_data = wb_result;
            default: e_store_data = q_b;
        endcase
    end

    assign alu_b = q_use_imm ? q_imm : e_store_data;

    always_comb begin
        case (q_alu_op)
            alu_sub: e_result = op_a - alu_b;
            alu_and: e_result = op_a & alu_b;
            alu_or:  e_result = op_a | alu_b;
            alu_slt: e_result = {31'b0, $signed(op_a) < $signed(alu_b)};
            alu_lui: e_result = {alu_b[15:0], 16'h0000};
            default: e_result = op_a + alu_b;
        endcase
    end

    // a store neither loads nor writes a register
    a_store_flags: assert property (
        @(posedge clk) disable iff (!rst_n) e_is_store |-> !e_reg_wen && !e_is_load
    ) else $error("store in execute also flagged as load or register write");

endmodule

// ==== verilog/decode.sv ====
module decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  mips_pkg::word_t     instr,
    input  mips_pkg::word_t     f_pc,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  mips_pkg::word_t     mem_result,
    input  mips_pkg::word_t     wb_result,
    input  mips_pkg::fwd_sel_t  br_fwd_a,
    input  mips_pkg::fwd_sel_t  br_fwd_b,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                uses_rs,
    output logic                uses_rt,
    output logic                is_branch,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    output mips_pkg::word_t     d_pc,
    output mips_pkg::word_t     d_a,
    output mips_pkg::word_t     d_b,
    output mips_pkg::word_t     d_imm,
    output mips_pkg::alu_op_t   d_alu_op,
    output logic                d_use_imm,
    output logic                d_reg_wen,
    output logic                d_is_load,
    output logic                d_is_store,
    output mips_pkg::reg_addr_t d_dest
);
    import mips_pkg::*;

    word_t   q_instr;
    opcode_t op;
    funct_t  fn;
    logic    is_jump;
    logic    is_bne;
    word_t   br_a;
    word_t   br_b;
    word_t   pc_plus4;

    // fetch/decode register, an all-zero word is sll $0 and decodes as a no-op
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_instr <= '0;
        end else if (!stall) begin
            q_instr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_pc <= f_pc;
        end
    end

    assign op    = opcode_t'(q_instr[31:26]);
    assign fn    = funct_t'(q_instr[5:0]);
    assign rs    = q_instr[25:21];
    assign rt    = q_instr[20:16];
    assign d_imm = {{16{q_instr[15]}}, q_instr[15:0]};
    assign d_a   = rs_data;
    assign d_b   = rt_data;

    always_comb begin
        d_alu_op   = alu_add;
        d_use_imm  = 1'b0;
        d_reg_wen  = 1'b0;
        d_is_load  = 1'b0;
        d_is_store = 1'b0;
        d_dest     = q_instr[15:11];
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        is_branch  = 1'b0;
        is_bne     = 1'b0;
        is_jump    = 1'b0;
        case (op)
            op_special: begin
                // unknown funct leaves everything low
                case (fn)
                    fn_addu: d_alu_op = alu_add;
                    fn_subu: d_alu_op = alu_sub;
                    fn_and:  d_alu_op = alu_and;
                    fn_or:   d_alu_op = alu_or;
                    fn_slt:  d_alu_op = alu_slt;
                    default: d_alu_op = alu_add;
                endcase
                d_reg_wen = (fn inside {fn_addu, fn_subu, fn_and, fn_or, fn_slt});
                uses_rs   = d_reg_wen;
                uses_rt   = d_reg_wen;
            end
            op_addiu, op_lui, op_lw: begin
                d_alu_op  = (op == op_lui) ? alu_lui : alu_add;
                d_use_imm = 1'b1;
                d_reg_wen = 1'b1;
                d_is_load = (op == op_lw);
                d_dest    = rt;
                uses_rs   = (op != op_lui);
            end
            op_sw: begin
                d_use_imm  = 1'b1;
                d_is_store = 1'b1;
                uses_rs    = 1'b1;
                uses_rt    = 1'b1;
            end
            op_beq, op_bne: begin
                is_branch = 1'b1;
                is_bne    = (op == op_bne);
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            op_j:    is_jump = 1'b1;
            default: is_jump = 1'b0;
        endcase
    end

    // comparator operands, youngest producer first
    always_comb begin
        case (br_fwd_a)
            fwd_mem: br_a = mem_result;
            fwd_wb:  br_a = wb_result;
            default: br_a = rs_data;
        endcase
        case (br_fwd_b)
            fwd_mem: br_b = mem_result;
            fwd_wb:  br_b = wb_result;
            default: br_b = rt_data;
        endcase
    end

    assign pc_plus4     = d_pc + 32'd4;
    assign branch_taken = is_jump || (is_branch && ((br_a == br_b) != is_bne));
    assign branch_target = is_jump ? {pc_plus4[31:28], q_instr[25:0], 2'b00}
                                   : pc_plus4 + {d_imm[29:0], 2'b00};

endmodule

// ==== verilog/fetch.sv ====
module fetch #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t pc
);
    import mips_pkg::*;

    word_t pc_next;

    // stall wins over a branch, the branch resolves again next cycle
    always_comb begin
        if (stall) begin
            pc_next = pc;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // targets from decode must keep the fetch address aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else $error("fetch address not word aligned: %h", pc);

endmodule

// ==== verilog/mips_pkg.sv ====
package mips_pkg;

    // machine word and register number
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // function field of special, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    // where an operand comes from
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

endpackage
